//--- verilog.f
+incdir+hw
hw/stream_pkg.sv
hw/bus_regs.sv
hw/stream_sources.sv
hw/rr_arbiter.sv
hw/word_fifo.sv
hw/stream_top.sv
verification/stream_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := stream_top_tb
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/stream_top_tb.sv
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_top_tb;
    import stream_pkg::*;

    // Eight drains of five bus reads per word, two cycles each, plus polling
    localparam int MAX_CYCLES = 8 * (`FIFO_DEPTH + 1) * 5 * 2 + 200;
    localparam bus_addr_t CTRL_ADDR   = `REGS_BASEADDR + `REG_CTRL_OFFS;
    localparam bus_addr_t PAT_ADDR    = `REGS_BASEADDR + `REG_PATTERN_OFFS;
    localparam bus_addr_t DATA_ADDR   = `FIFO_BASEADDR + `FIFO_DATA_OFFS;
    localparam bus_addr_t COUNT_ADDR  = `FIFO_BASEADDR + `FIFO_COUNT_OFFS;
    localparam bus_addr_t STATUS_ADDR = `FIFO_BASEADDR + `FIFO_STATUS_OFFS;

    logic         BUS_CLK = 1'b0;
    logic         BUS_RST;
    bus_addr_t    bus_add;
    bus_byte_t    bus_data;
    logic         bus_rd;
    logic         bus_wr;
    bus_byte_t    bus_rdata;

    int           seed   = 47;
    int           errors = 0;
    int           cycles = 0;

    bus_byte_t    m_ctrl;
    stream_word_t m_pat;
    bus_byte_t    m_cnt;          // Low byte of the next counter word
    int           m_last;         // Last granted source
    logic [1:0]   m_lane;
    stream_word_t m_q [$];
    stream_word_t m_popped [$];   // Words freed by the fourth byte read
    bus_byte_t    m_rdata;

    stream_top dut (
        .BUS_CLK   (BUS_CLK),
        .BUS_RST   (BUS_RST),
        .bus_add   (bus_add),
        .bus_data  (bus_data),
        .bus_rd    (bus_rd),
        .bus_wr    (bus_wr),
        .bus_rdata (bus_rdata)
    );

    always #5 BUS_CLK = ~BUS_CLK;

    always @(posedge BUS_CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic stream_word_t counter_word(bus_byte_t b);
        return {b + 8'd3, b + 8'd2, b + 8'd1, b};
    endfunction

    function automatic logic is_pat_addr(bus_addr_t a);
        return (a >= PAT_ADDR) && (a < PAT_ADDR + 16'd4);
    endfunction

    function automatic bus_byte_t expected_read(bus_addr_t a);
        stream_word_t head;
        head = (m_q.size() > 0) ? m_q[0] : '0;
        if (a == CTRL_ADDR) return m_ctrl;
        if (is_pat_addr(a)) return m_pat[8 * int'(a[1:0]) +: 8];
        if (a == DATA_ADDR) return head[8 * int'(m_lane) +: 8];    // Zero when empty
        if (a == COUNT_ADDR) return bus_byte_t'(m_q.size());
        if (a == STATUS_ADDR) return {6'b0, m_q.size() == `FIFO_DEPTH, m_q.size() == 0};
        return '0;
    endfunction

    // ***********************************************************************
    // Reference model, stepped on the DUT's sampling edges
    // ***********************************************************************

    always @(posedge BUS_CLK) begin
        int           sel;
        int           c;
        logic         full_now;
        stream_word_t w;
        sel = -1;
        w   = '0;
        if (BUS_RST) begin
            m_ctrl  = '0;
            m_pat   = '0;
            m_cnt   = '0;
            m_last  = `NUM_SOURCES - 1;    // Counter goes first
            m_lane  = '0;
            m_rdata = '0;
            m_q.delete();
        end else begin
            full_now = (m_q.size() == `FIFO_DEPTH);
            if (bus_rd) m_rdata = expected_read(bus_add);
            for (int i = 1; i <= `NUM_SOURCES; i++) begin
                c = (m_last + i) % `NUM_SOURCES;
                if (sel < 0 && !full_now && m_ctrl[c]) sel = c;
            end
            if (sel == 0) begin
                w     = counter_word(m_cnt);
                m_cnt = m_cnt + 8'd4;
            end else if (sel == 1) begin
                w = m_pat;
            end
            if (sel >= 0) m_last = sel;
            if (bus_rd && bus_add == DATA_ADDR && m_q.size() > 0) begin
                if (m_lane == 2'd3) m_popped.push_back(m_q.pop_front());
                m_lane = m_lane + 2'd1;
            end
            if (bus_wr && bus_add == DATA_ADDR) begin
                m_q.delete();    // Clear drops a word granted in the same cycle
                m_lane = '0;
            end else if (sel >= 0) begin
                m_q.push_back(w);
            end
            if (bus_wr && bus_add == CTRL_ADDR) m_ctrl = bus_data;
            if (bus_wr && is_pat_addr(bus_add)) m_pat[8 * int'(bus_add[1:0]) +: 8] = bus_data;
        end
    end

    task automatic check_byte(string name, bus_byte_t got, bus_byte_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %02h expected %02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(string name, stream_word_t got, stream_word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %08h expected %08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_write(bus_addr_t a, bus_byte_t d);
        @(posedge BUS_CLK);
        bus_add  <= a;
        bus_data <= d;
        bus_wr   <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr   <= 1'b0;
    endtask

    task automatic bus_read(bus_addr_t a, output bus_byte_t d);
        @(posedge BUS_CLK);
        bus_add <= a;
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd  <= 1'b0;
        @(negedge BUS_CLK);
        d = bus_rdata;
        check_byte("bus_rdata", d, m_rdata);
    endtask

    task automatic drain_word(output stream_word_t w);
        bus_byte_t b;
        for (int i = 0; i < 4; i++) begin
            bus_read(DATA_ADDR, b);
            w[8*i +: 8] = b;
        end
        if (m_popped.size() == 0) begin
            $display("Model popped no word after four data reads at %0t", $time);
            errors++;
        end else begin
            check_word("fifo word", w, m_popped.pop_front());
        end
    endtask

    task automatic wait_full();
        bus_byte_t st;
        st = '0;
        while (st[1] !== 1'b1) bus_read(STATUS_ADDR, st);
    endtask

    initial begin
        stream_word_t w;
        stream_word_t pat_w;
        bus_byte_t    b;
        bus_byte_t    cval;
        int           src;
        BUS_RST  = 1'b1;
        bus_add  = '0;
        bus_data = '0;
        bus_rd   = 1'b0;
        bus_wr   = 1'b0;
        repeat (3) @(posedge BUS_CLK);
        BUS_RST <= 1'b0;

        // Register readback, source enables kept low
        for (int i = 0; i < 8; i++) begin
            bus_write(CTRL_ADDR, bus_byte_t'($random(seed)) & 8'hFC);
            bus_read(CTRL_ADDR, b);
            bus_write(PAT_ADDR + bus_addr_t'(i % 4), bus_byte_t'($random(seed)));
            bus_read(PAT_ADDR + bus_addr_t'(i % 4), b);
        end

        // Counter only
        bus_write(CTRL_ADDR, 8'h01);
        wait_full();
        bus_write(CTRL_ADDR, 8'h00);
        bus_read(COUNT_ADDR, b);
        check_byte("fifo count", b, bus_byte_t'(`FIFO_DEPTH));
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            drain_word(w);
            check_word("counter word", w, counter_word(bus_byte_t'(4 * i)));
        end

        // Pattern only
        bus_write(DATA_ADDR, 8'h00);
        for (int i = 0; i < 4; i++) begin
            b = bus_byte_t'($random(seed));
            pat_w[8*i +: 8] = b;
            bus_write(PAT_ADDR + bus_addr_t'(i), b);
        end
        bus_write(CTRL_ADDR, 8'h02);
        wait_full();
        bus_write(CTRL_ADDR, 8'h00);
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            bus_read(COUNT_ADDR, b);
            check_byte("fifo count", b, bus_byte_t'(`FIFO_DEPTH - i));
            drain_word(w);
            check_word("pattern word", w, pat_w);
        end

        // Both sources, alternating from the model pointer
        bus_write(DATA_ADDR, 8'h00);
        src  = (m_last + 1) % `NUM_SOURCES;
        cval = bus_byte_t'(4 * `FIFO_DEPTH);
        bus_write(CTRL_ADDR, 8'h03);
        wait_full();
        bus_write(CTRL_ADDR, 8'h00);
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            drain_word(w);
            if (src == 0) begin
                check_word("counter word", w, counter_word(cval));
                cval = cval + 8'd4;
            end else begin
                check_word("pattern word", w, pat_w);
            end
            src = 1 - src;
        end

        // Back-pressure with the counter left running
        bus_write(DATA_ADDR, 8'h00);
        bus_write(CTRL_ADDR, 8'h01);
        wait_full();
        bus_read(STATUS_ADDR, b);
        check_byte("fifo status", b, 8'h02);
        drain_word(w);
        check_word("counter word", w, counter_word(cval));
        cval = cval + 8'd4;
        wait_full();
        bus_write(CTRL_ADDR, 8'h00);
        bus_read(COUNT_ADDR, b);
        check_byte("fifo count", b, bus_byte_t'(`FIFO_DEPTH));
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            drain_word(w);
            check_word("counter word", w, counter_word(cval));
            cval = cval + 8'd4;
        end
        bus_read(STATUS_ADDR, b);
        check_byte("fifo status", b, 8'h01);

        // Clear with words present
        bus_write(CTRL_ADDR, 8'h01);
        bus_write(CTRL_ADDR, 8'h00);
        bus_read(COUNT_ADDR, b);
        bus_write(DATA_ADDR, 8'h00);
        bus_read(STATUS_ADDR, b);
        check_byte("fifo status", b, 8'h01);
        bus_read(COUNT_ADDR, b);
        check_byte("fifo count", b, 8'h00);
        bus_read(DATA_ADDR, b);
        check_byte("fifo data", b, 8'h00);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- hw/stream_top.sv
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_top (
    input  logic                  BUS_CLK,
    input  logic                  BUS_RST,
    input  stream_pkg::bus_addr_t bus_add,
    input  stream_pkg::bus_byte_t bus_data,
    input  logic                  bus_rd,
    input  logic                  bus_wr,
    output stream_pkg::bus_byte_t bus_rdata
);
    import stream_pkg::*;

    bus_byte_t                regs_rdata;
    bus_byte_t                fifo_rdata;
    logic                     counter_en;
    logic                     pattern_en;
    stream_word_t             pattern;
    logic [`NUM_SOURCES-1:0]  src_req;
    logic [`NUM_SOURCES-1:0]  src_grant;
    stream_word_t             src_data [`NUM_SOURCES];
    logic                     wr_en;
    stream_word_t             wr_data;
    logic                     fifo_ready;

    // Each block returns zero outside its own range
    assign bus_rdata = regs_rdata | fifo_rdata;

    bus_regs i_bus_regs (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .bus_add    (bus_add),
        .bus_data   (bus_data),
        .bus_rd     (bus_rd),
        .bus_wr     (bus_wr),
        .bus_rdata  (regs_rdata),
        .counter_en (counter_en),
        .pattern_en (pattern_en),
        .pattern    (pattern)
    );

    stream_sources i_sources (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .counter_en (counter_en),
        .pattern_en (pattern_en),
        .pattern    (pattern),
        .src_grant  (src_grant),
        .src_req    (src_req),
        .src_data   (src_data)
    );

    rr_arbiter #(
        .PAYLOAD_T (stream_word_t),
        .N         (`NUM_SOURCES)
    ) i_arbiter (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST),
        .req     (src_req),
        .data_in (src_data),
        .ready   (fifo_ready),
        .grant   (src_grant),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    word_fifo i_fifo (
        .BUS_CLK   (BUS_CLK),
        .BUS_RST   (BUS_RST),
        .bus_add   (bus_add),
        .bus_rd    (bus_rd),
        .bus_wr    (bus_wr),
        .bus_rdata (fifo_rdata),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .ready     (fifo_ready)
    );

endmodule

//--- hw/word_fifo.sv
`timescale 1ns/1ps
`include "stream_defs.svh"

module word_fifo (
    input  logic                     BUS_CLK,
    input  logic                     BUS_RST,
    input  stream_pkg::bus_addr_t    bus_add,
    input  logic                     bus_rd,
    input  logic                     bus_wr,
    output stream_pkg::bus_byte_t    bus_rdata,
    input  logic                     wr_en,
    input  stream_pkg::stream_word_t wr_data,
    output logic                     ready
);
    import stream_pkg::*;

    localparam int AW = $clog2(`FIFO_DEPTH);

    stream_word_t  mem [`FIFO_DEPTH];
    stream_word_t  head;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [1:0]    lane;       // Next byte of the head word
    fifo_count_t   count;
    logic          full;
    logic          empty;
    bus_addr_t     offs;
    bus_byte_t     rd_byte;
    logic          in_range;
    logic          clear;
    logic          data_rd;
    logic          push;
    logic          pop;

    assign offs     = bus_add - `FIFO_BASEADDR;
    assign in_range = offs <= (`FIFO_HIGHADDR - `FIFO_BASEADDR);

    assign full  = (count == fifo_count_t'(`FIFO_DEPTH));
    assign empty = (count == '0);
    assign ready = !full;

    assign clear   = bus_wr && in_range && (offs == `FIFO_DATA_OFFS);
    assign data_rd = bus_rd && in_range && (offs == `FIFO_DATA_OFFS);
    assign push    = wr_en && !full;
    assign pop     = data_rd && !empty && (lane == 2'd3);    // Fourth byte frees the word

    // ***********************************************************************
    // Storage and pointers
    // ***********************************************************************

    always_ff @(posedge BUS_CLK) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Clear wins over a push in the same cycle
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            lane   <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (data_rd && !empty) begin
                lane <= lane + 2'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ***********************************************************************
    // Bus readback
    // ***********************************************************************

    assign head = mem[rd_ptr];

    always_comb begin
        rd_byte = '0;
        if (in_range) begin
            case (offs)
                `FIFO_DATA_OFFS:   rd_byte = empty ? '0 : head[{lane, 3'b000} +: 8];
                `FIFO_COUNT_OFFS:  rd_byte = bus_byte_t'(count);
                `FIFO_STATUS_OFFS: rd_byte = {6'b0, full, empty};
                default:           rd_byte = '0;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            bus_rdata <= '0;
        end else if (bus_rd) begin
            bus_rdata <= rd_byte;
        end
    end

    // Arbiter sees ready low and must hold off
    a_no_write_full: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        full |-> !wr_en);

    a_count_ptrs: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        count[AW-1:0] == AW'(wr_ptr - rd_ptr));

endmodule

//--- hw/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
    parameter type PAYLOAD_T = logic [31:0],
    parameter int  N         = 2
) (
    input  logic         BUS_CLK,
    input  logic         BUS_RST,
    input  logic [N-1:0] req,
    input  PAYLOAD_T     data_in [N],
    input  logic         ready,
    output logic [N-1:0] grant,
    output logic         wr_en,
    output PAYLOAD_T     wr_data
);

    localparam int IW = (N > 1) ? $clog2(N) : 1;

    logic [IW-1:0] last;    // Index of the last granted source
    logic [IW-1:0] sel;
    logic          found;

    // ***********************************************************************
    // Pick the first requester after the last grant
    // ***********************************************************************

    always_comb begin
        int cand;
        sel   = last;
        found = 1'b0;
        for (int i = 1; i <= N; i++) begin
            cand = (int'(last) + i) % N;
            if (!found && req[cand]) begin
                sel   = IW'(cand);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found && ready) begin
            grant[sel] = 1'b1;
        end
    end

    assign wr_en   = found && ready;
    assign wr_data = data_in[sel];

    // Starts at N-1 so source 0 wins first
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            last <= IW'(N - 1);
        end else if (wr_en) begin
            last <= sel;
        end
    end

    // Steady requesters take turns
    a_rr_turns: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        (wr_en && (&req)) |=> (!(wr_en && (&req)) || (grant != $past(grant))));

endmodule

//--- hw/stream_sources.sv
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_sources (
    input  logic                      BUS_CLK,
    input  logic                      BUS_RST,
    input  logic                      counter_en,
    input  logic                      pattern_en,
    input  stream_pkg::stream_word_t  pattern,
    input  logic [`NUM_SOURCES-1:0]   src_grant,
    output logic [`NUM_SOURCES-1:0]   src_req,
    output stream_pkg::stream_word_t  src_data [`NUM_SOURCES]
);
    import stream_pkg::*;

    localparam int SRC_COUNTER = 0;
    localparam int SRC_PATTERN = 1;

    bus_byte_t count;
    bus_byte_t count_byte [4];

    // Advances only on a grant, so a stalled word is never skipped
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            count <= '0;
        end else if (src_grant[SRC_COUNTER]) begin
            count <= count + 8'd4;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            count_byte[i] = count + bus_byte_t'(i);    // Wraps mod 256
        end
    end

    assign src_data[SRC_COUNTER] = {count_byte[3], count_byte[2], count_byte[1], count_byte[0]};
    assign src_data[SRC_PATTERN] = pattern;

    assign src_req[SRC_COUNTER] = counter_en;
    assign src_req[SRC_PATTERN] = pattern_en;

endmodule

//--- hw/bus_regs.sv
`timescale 1ns/1ps
`include "stream_defs.svh"

module bus_regs (
    input  logic                     BUS_CLK,
    input  logic                     BUS_RST,
    input  stream_pkg::bus_addr_t    bus_add,
    input  stream_pkg::bus_byte_t    bus_data,
    input  logic                     bus_rd,
    input  logic                     bus_wr,
    output stream_pkg::bus_byte_t    bus_rdata,
    output logic                     counter_en,
    output logic                     pattern_en,
    output stream_pkg::stream_word_t pattern
);
    import stream_pkg::*;

    bus_byte_t ctrl;           // Bits 7:2 reserved, kept as written
    bus_byte_t pat_byte [4];
    bus_byte_t rd_byte;
    bus_addr_t offs;
    logic      in_range;
    logic      is_ctrl;
    logic      is_pat;

    // Unsigned offset compare covers both ends of the range
    assign offs     = bus_add - `REGS_BASEADDR;
    assign in_range = offs <= (`REGS_HIGHADDR - `REGS_BASEADDR);
    assign is_ctrl  = in_range && (offs == `REG_CTRL_OFFS);
    assign is_pat   = in_range && (offs >= `REG_PATTERN_OFFS) &&
                      (offs < (`REG_PATTERN_OFFS + 16'd4));

    // ***********************************************************************
    // Register writes
    // ***********************************************************************

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            ctrl     <= '0;
            pat_byte <= '{default: '0};
        end else if (bus_wr) begin
            if (is_ctrl) begin
                ctrl <= bus_data;
            end
            if (is_pat) begin
                pat_byte[offs[1:0]] <= bus_data;
            end
        end
    end

    assign counter_en = ctrl[0];
    assign pattern_en = ctrl[1];
    assign pattern    = {pat_byte[3], pat_byte[2], pat_byte[1], pat_byte[0]};

    // Readback, zero outside our range
    always_comb begin
        rd_byte = '0;
        if (is_ctrl) begin
            rd_byte = ctrl;
        end else if (is_pat) begin
            rd_byte = pat_byte[offs[1:0]];
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            bus_rdata <= '0;
        end else if (bus_rd) begin
            bus_rdata <= rd_byte;    // Held until next read
        end
    end

endmodule

//--- hw/stream_pkg.sv
package stream_pkg;

    // ***********************************************************************
    // Host bus
    // ***********************************************************************

    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_byte_t;

    // ***********************************************************************
    // Stream payload and buffer
    // ***********************************************************************

    // Byte 0 sits in bits 7:0
    typedef logic [31:0] stream_word_t;

    // Holds 0 up to FIFO_DEPTH
    typedef logic [7:0]  fifo_count_t;

endpackage

//--- hw/stream_defs.svh
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

// Register block range
`define REGS_BASEADDR     16'h0000
`define REGS_HIGHADDR     16'h001F
`define REG_CTRL_OFFS     16'h0000
`define REG_PATTERN_OFFS  16'h0010    // Four bytes, little-endian

// Buffer range
`define FIFO_BASEADDR     16'h0020
`define FIFO_HIGHADDR     16'h002F
`define FIFO_DATA_OFFS    16'h0000    // Read pops a byte, write clears
`define FIFO_COUNT_OFFS   16'h0001
`define FIFO_STATUS_OFFS  16'h0002    // Bit 0 empty, bit 1 full

`define FIFO_DEPTH        16
`define NUM_SOURCES       2

`endif
